/* riscv_pipe_cfg.svh */
`ifndef RISCV_PIPE_CFG_SVH
`define RISCV_PIPE_CFG_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------

// Data and address word
`define XLEN        32

// Register index, 32 architectural registers
`define REG_ADDR_W  5

// ------------------------------------------------------------
// Fixed values
// ------------------------------------------------------------

// First fetch address out of reset
`define RESET_PC    32'h0000_0000

// addi x0, x0, 0 used as the bubble
`define NOP_INSN    32'h0000_0013

`endif

/* riscv_pipe_pkg.sv */
`include "riscv_pipe_cfg.svh"

package riscv_pipe_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------

    // Data or address word
    typedef logic [`XLEN-1:0]       word_t;

    // Register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [3:0]             alu_op_t;
    typedef logic [1:0]             fwd_sel_t;

    // ------------------------------------------------------------
    // ALU operation codes
    // ------------------------------------------------------------
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // Execute operand source
    localparam fwd_sel_t FWD_RF  = 2'b00;
    // Value being written back this cycle
    localparam fwd_sel_t FWD_WB  = 2'b01;
    // ALU result sitting in EX/MEM
    localparam fwd_sel_t FWD_MEM = 2'b10;

endpackage

/* riscv_decoder.sv */
`timescale 1ns/1ps

module riscv_decoder (
    input  riscv_pipe_pkg::word_t     inst_i,
    output riscv_pipe_pkg::reg_addr_t rs1_o,
    output riscv_pipe_pkg::reg_addr_t rs2_o,
    output riscv_pipe_pkg::reg_addr_t rd_o,
    output riscv_pipe_pkg::word_t     imm_o,
    output riscv_pipe_pkg::alu_op_t   alu_op_o,
    output logic                      alu_src_imm_o,
    output logic                      reg_write_o,
    output logic                      mem_read_o,
    output logic                      mem_write_o,
    output logic                      branch_o,
    output logic                      branch_ne_o
);
    import riscv_pipe_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;

    // Shared by register and immediate forms, sub only exists for registers
    function automatic alu_op_t arith_op(logic [2:0] f3, logic alt, logic is_reg);
        case (f3)
            3'b000:  arith_op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];

    // Sign-extended immediates
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    always_comb begin
        rs1_o         = inst_i[19:15];
        rs2_o         = '0;
        rd_o          = '0;
        imm_o         = imm_i;
        alu_op_o      = ALU_ADD;
        alu_src_imm_o = 1'b0;
        reg_write_o   = 1'b0;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        branch_o      = 1'b0;
        branch_ne_o   = 1'b0;
        case (opcode)
            OPC_OP: begin
                rs2_o       = inst_i[24:20];
                rd_o        = inst_i[11:7];
                reg_write_o = 1'b1;
                alu_op_o    = arith_op(funct3, funct7_b5, 1'b1);
            end
            OPC_OP_IMM: begin
                rd_o          = inst_i[11:7];
                reg_write_o   = 1'b1;
                alu_src_imm_o = 1'b1;
                alu_op_o      = arith_op(funct3, funct7_b5, 1'b0);
            end
            OPC_LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) begin
                    rd_o          = inst_i[11:7];
                    reg_write_o   = 1'b1;
                    mem_read_o    = 1'b1;
                    alu_src_imm_o = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    rs2_o         = inst_i[24:20];
                    imm_o         = imm_s;
                    mem_write_o   = 1'b1;
                    alu_src_imm_o = 1'b1;
                end
            end
            OPC_BRANCH: begin
                // beq and bne compare through a subtract
                if (funct3[2:1] == 2'b00) begin
                    rs2_o       = inst_i[24:20];
                    imm_o       = imm_b;
                    alu_op_o    = ALU_SUB;
                    branch_o    = 1'b1;
                    branch_ne_o = funct3[0];
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* riscv_regfile.sv */
`timescale 1ns/1ps
`include "riscv_pipe_cfg.svh"

module riscv_regfile (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      wr_en_i,
    input  riscv_pipe_pkg::reg_addr_t wr_addr_i,
    input  riscv_pipe_pkg::word_t     wr_data_i,
    input  riscv_pipe_pkg::reg_addr_t rd1_addr_i,
    input  riscv_pipe_pkg::reg_addr_t rd2_addr_i,
    output riscv_pipe_pkg::word_t     rd1_data_o,
    output riscv_pipe_pkg::word_t     rd2_data_o
);
    import riscv_pipe_pkg::*;

    // x0 has no storage
    word_t regs [1:(1 << `REG_ADDR_W) - 1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Same-cycle write shows up on the read ports
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 :
                        (wr_en_i && (wr_addr_i == rd1_addr_i)) ? wr_data_i : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 :
                        (wr_en_i && (wr_addr_i == rd2_addr_i)) ? wr_data_i : regs[rd2_addr_i];

endmodule

/* riscv_alu.sv */
`timescale 1ns/1ps

module riscv_alu (
    input  riscv_pipe_pkg::alu_op_t op_i,
    input  riscv_pipe_pkg::word_t   a_i,
    input  riscv_pipe_pkg::word_t   b_i,
    output riscv_pipe_pkg::word_t   result_o,
    output logic                    zero_o
);
    import riscv_pipe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = word_t'(a_i < b_i);
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = a_i + b_i;
        endcase
    end

    // Branch compare result
    assign zero_o = (result_o == '0);

endmodule

/* riscv_hazard_unit.sv */
`timescale 1ns/1ps

module riscv_hazard_unit (
    input  riscv_pipe_pkg::reg_addr_t id_rs1_i,
    input  riscv_pipe_pkg::reg_addr_t id_rs2_i,
    input  riscv_pipe_pkg::reg_addr_t ex_rs1_i,
    input  riscv_pipe_pkg::reg_addr_t ex_rs2_i,
    input  riscv_pipe_pkg::reg_addr_t ex_rd_i,
    input  logic                      ex_mem_read_i,
    input  riscv_pipe_pkg::reg_addr_t mem_rd_i,
    input  logic                      mem_reg_write_i,
    input  riscv_pipe_pkg::reg_addr_t wb_rd_i,
    input  logic                      wb_reg_write_i,
    output riscv_pipe_pkg::fwd_sel_t  fwd_a_o,
    output riscv_pipe_pkg::fwd_sel_t  fwd_b_o,
    output logic                      stall_o
);
    import riscv_pipe_pkg::*;

    // Youngest producer wins, x0 never forwards
    function automatic fwd_sel_t pick_src(reg_addr_t rs, reg_addr_t m_rd, logic m_we,
                                          reg_addr_t w_rd, logic w_we);
        if (m_we && (m_rd != '0) && (m_rd == rs)) begin
            pick_src = FWD_MEM;
        end else if (w_we && (w_rd != '0) && (w_rd == rs)) begin
            pick_src = FWD_WB;
        end else begin
            pick_src = FWD_RF;
        end
    endfunction

    // ------------------------------------------------------------
    // Execute operand forwarding
    // ------------------------------------------------------------
    assign fwd_a_o = pick_src(ex_rs1_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);
    assign fwd_b_o = pick_src(ex_rs2_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);

    // ------------------------------------------------------------
    // Load-use detection
    // ------------------------------------------------------------

    // Load data is only ready once the load reaches writeback
    assign stall_o = ex_mem_read_i && (ex_rd_i != '0) &&
                     ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

endmodule

/* riscv_pipe_core.sv */
`timescale 1ns/1ps
`include "riscv_pipe_cfg.svh"

module riscv_pipe_core (
    input  logic                  clk,
    input  logic                  rst_n_i,
    output riscv_pipe_pkg::word_t pc_o,
    input  riscv_pipe_pkg::word_t inst_i,
    output riscv_pipe_pkg::word_t mem_addr_o,
    output riscv_pipe_pkg::word_t mem_wdata_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    input  riscv_pipe_pkg::word_t mem_rdata_i
);
    import riscv_pipe_pkg::*;

    // Fetch and IF/ID
    word_t     pc, pc_plus4, id_pc, id_inst;
    // Decode
    reg_addr_t id_rs1, id_rs2, id_rd;
    word_t     id_imm, id_rs1_data, id_rs2_data;
    alu_op_t   id_alu_op;
    logic      id_alu_src_imm, id_reg_write, id_mem_read, id_mem_write, id_branch, id_branch_ne;
    logic      stall;
    // ID/EX and execute
    word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    alu_op_t   ex_alu_op;
    logic      ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_branch_ne;
    fwd_sel_t  fwd_a, fwd_b;
    word_t     ex_op_a, ex_op_b, ex_alu_b, ex_alu_result, branch_target;
    logic      ex_zero, branch_taken;
    // EX/MEM and MEM/WB
    word_t     mem_alu_result, mem_store_data, wb_alu_result, wb_load_data, wb_data;
    reg_addr_t mem_rd, wb_rd;
    logic      mem_reg_write, mem_mem_read, mem_mem_write, wb_reg_write, wb_mem_read;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val, word_t wb_val,
                                      word_t mem_val);
        case (sel)
            FWD_MEM: fwd_mux = mem_val;
            FWD_WB:  fwd_mux = wb_val;
            default: fwd_mux = rf_val;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Fetch
    // ------------------------------------------------------------
    assign pc_plus4 = pc + 32'd4;
    assign pc_o     = pc;

    // Redirect wins over the load-use hold
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc      <= `RESET_PC;
            id_pc   <= `RESET_PC;
            id_inst <= `NOP_INSN;
        end else if (branch_taken) begin
            pc      <= branch_target;
            id_inst <= `NOP_INSN;
        end else if (!stall) begin
            pc      <= pc_plus4;
            id_pc   <= pc;
            id_inst <= inst_i;
        end
    end

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    riscv_decoder u_dec (
        .inst_i        (id_inst),
        .rs1_o         (id_rs1),
        .rs2_o         (id_rs2),
        .rd_o          (id_rd),
        .imm_o         (id_imm),
        .alu_op_o      (id_alu_op),
        .alu_src_imm_o (id_alu_src_imm),
        .reg_write_o   (id_reg_write),
        .mem_read_o    (id_mem_read),
        .mem_write_o   (id_mem_write),
        .branch_o      (id_branch),
        .branch_ne_o   (id_branch_ne)
    );

    riscv_regfile u_rf (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wb_reg_write),
        .wr_addr_i  (wb_rd),
        .wr_data_i  (wb_data),
        .rd1_addr_i (id_rs1),
        .rd2_addr_i (id_rs2),
        .rd1_data_o (id_rs1_data),
        .rd2_data_o (id_rs2_data)
    );

    riscv_hazard_unit u_hz (
        .id_rs1_i        (id_rs1),
        .id_rs2_i        (id_rs2),
        .ex_rs1_i        (ex_rs1),
        .ex_rs2_i        (ex_rs2),
        .ex_rd_i         (ex_rd),
        .ex_mem_read_i   (ex_mem_read),
        .mem_rd_i        (mem_rd),
        .mem_reg_write_i (mem_reg_write),
        .wb_rd_i         (wb_rd),
        .wb_reg_write_i  (wb_reg_write),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b),
        .stall_o         (stall)
    );

    // ID/EX strobes, cleared for a bubble on stall or flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_branch_ne} <= '0;
        end else if (branch_taken || stall) begin
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_branch_ne} <= '0;
        end else begin
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_branch_ne} <=
                {id_reg_write, id_mem_read, id_mem_write, id_branch, id_branch_ne};
        end
    end

    always_ff @(posedge clk) begin
        ex_pc          <= id_pc;
        ex_rs1_data    <= id_rs1_data;
        ex_rs2_data    <= id_rs2_data;
        ex_imm         <= id_imm;
        ex_rs1         <= id_rs1;
        ex_rs2         <= id_rs2;
        ex_rd          <= id_rd;
        ex_alu_op      <= id_alu_op;
        ex_alu_src_imm <= id_alu_src_imm;
    end

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    assign ex_op_a  = fwd_mux(fwd_a, ex_rs1_data, wb_data, mem_alu_result);
    assign ex_op_b  = fwd_mux(fwd_b, ex_rs2_data, wb_data, mem_alu_result);
    assign ex_alu_b = ex_alu_src_imm ? ex_imm : ex_op_b;

    riscv_alu u_alu (
        .op_i     (ex_alu_op),
        .a_i      (ex_op_a),
        .b_i      (ex_alu_b),
        .result_o (ex_alu_result),
        .zero_o   (ex_zero)
    );

    // beq on zero, bne on nonzero
    assign branch_target = ex_pc + ex_imm;
    assign branch_taken  = ex_branch && (ex_zero != ex_branch_ne);

    // ------------------------------------------------------------
    // Memory and writeback
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            {mem_reg_write, mem_mem_read, mem_mem_write} <= '0;
            {wb_reg_write, wb_mem_read}                  <= '0;
        end else begin
            {mem_reg_write, mem_mem_read, mem_mem_write} <=
                {ex_reg_write, ex_mem_read, ex_mem_write};
            {wb_reg_write, wb_mem_read} <= {mem_reg_write, mem_mem_read};
        end
    end

    always_ff @(posedge clk) begin
        mem_alu_result <= ex_alu_result;
        mem_store_data <= ex_op_b;
        mem_rd         <= ex_rd;
        wb_alu_result  <= mem_alu_result;
        wb_load_data   <= mem_rdata_i;
        wb_rd          <= mem_rd;
    end

    assign mem_addr_o  = mem_alu_result;
    assign mem_wdata_o = mem_store_data;
    assign mem_read_o  = mem_mem_read;
    assign mem_write_o = mem_mem_write;

    assign wb_data = wb_mem_read ? wb_load_data : wb_alu_result;

endmodule

/* riscv_pipe_props.sv */
`timescale 1ns/1ps

module riscv_pipe_props (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  riscv_pipe_pkg::word_t pc_i,
    input  logic                  stall_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i
);

    // Data port is either a read or a write
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_read_i && mem_write_i))
        else $error("mem_read_o and mem_write_o are high in the same cycle");

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_i[1:0] == 2'b00)
        else $error("pc_o is not word aligned");

    // Load-use hold
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(pc_i))
        else $error("pc_o moved during a load-use stall");

    a_rst_quiet: assert property (@(posedge clk)
        !rst_n_i |-> (!mem_read_i && !mem_write_i))
        else $error("Memory strobe active during reset");

endmodule

bind riscv_pipe_core riscv_pipe_props u_props (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .pc_i        (pc_o),
    .stall_i     (stall),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o)
);

/* riscv_pipe_checker.sv */
`timescale 1ns/1ps
`include "riscv_pipe_cfg.svh"

module riscv_pipe_checker (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  riscv_pipe_pkg::word_t pc_i,
    input  logic                  mem_write_i,
    input  riscv_pipe_pkg::word_t mem_addr_i,
    input  riscv_pipe_pkg::word_t mem_wdata_i,
    input  int                    exp_count_i,
    input  riscv_pipe_pkg::word_t exp_addr_i,
    input  riscv_pipe_pkg::word_t exp_data_i,
    output int                    store_idx_o,
    output int                    mismatch_cnt_o,
    output int                    extra_cnt_o,
    output logic                  done_o
);
    import riscv_pipe_pkg::*;

    logic first_cycle;

    // ------------------------------------------------------------
    // Reset pc and store stream compare
    // ------------------------------------------------------------
    always @(posedge clk or negedge rst_n_i) begin
        int bad;
        if (!rst_n_i) begin
            store_idx_o    <= 0;
            mismatch_cnt_o <= 0;
            extra_cnt_o    <= 0;
            first_cycle    <= 1'b1;
        end else begin
            bad = 0;
            first_cycle <= 1'b0;
            if (first_cycle && (pc_i != `RESET_PC)) begin
                $display("** Error at %0d ns: pc_o expected %08h, actual %08h",
                         $time, `RESET_PC, pc_i);
                bad++;
            end
            if (mem_write_i && (store_idx_o >= exp_count_i)) begin
                $display("Unexpected store of %08h to address %08h at %0d ns",
                         mem_wdata_i, mem_addr_i, $time);
                extra_cnt_o <= extra_cnt_o + 1;
            end else if (mem_write_i) begin
                if (mem_addr_i != exp_addr_i) begin
                    $display("** Error at %0d ns: mem_addr_o expected %08h, actual %08h",
                             $time, exp_addr_i, mem_addr_i);
                    bad++;
                end
                if (mem_wdata_i != exp_data_i) begin
                    $display("** Error at %0d ns: mem_wdata_o expected %08h, actual %08h",
                             $time, exp_data_i, mem_wdata_i);
                    bad++;
                end
                store_idx_o <= store_idx_o + 1;
            end
            mismatch_cnt_o <= mismatch_cnt_o + bad;
        end
    end

    assign done_o = (store_idx_o == exp_count_i);

endmodule

/* tb_riscv_pipe_core.sv */
`timescale 1ns/1ps
`include "riscv_pipe_cfg.svh"

module tb_clk_gen (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end
endmodule

module tb_riscv_pipe_core;
    import riscv_pipe_pkg::*;

    logic  clk;
    logic  rst_n;
    word_t pc, inst, mem_addr, mem_wdata, mem_rdata;
    logic  mem_read, mem_write;

    word_t stim [0:255];
    word_t prog [0:63];
    word_t exp_addr [0:63];
    word_t exp_data [0:63];
    word_t dmem [0:255];
    int    prog_len;
    int    store_len;
    int    store_idx, mismatch_cnt, extra_cnt;
    logic  done;
    word_t exp_addr_cur, exp_data_cur;

    tb_clk_gen u_clk (.clk_o(clk));

    riscv_pipe_core dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .pc_o        (pc),
        .inst_i      (inst),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .mem_rdata_i (mem_rdata)
    );

    assign exp_addr_cur = exp_addr[store_idx[5:0]];
    assign exp_data_cur = exp_data[store_idx[5:0]];

    riscv_pipe_checker u_chk (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .pc_i           (pc),
        .mem_write_i    (mem_write),
        .mem_addr_i     (mem_addr),
        .mem_wdata_i    (mem_wdata),
        .exp_count_i    (store_len),
        .exp_addr_i     (exp_addr_cur),
        .exp_data_i     (exp_data_cur),
        .store_idx_o    (store_idx),
        .mismatch_cnt_o (mismatch_cnt),
        .extra_cnt_o    (extra_cnt),
        .done_o         (done)
    );

    // ------------------------------------------------------------
    // Stimulus file and memory models
    // ------------------------------------------------------------

    // Count, program words, store count, then address and data pairs
    task automatic load_stimulus();
        int pos;
        $readmemh("riscv_pipe_stimulus.hex", stim);
        prog_len = int'(stim[0][6:0]);
        for (int k = 0; k < 64; k++) begin
            prog[k[5:0]] = (k < prog_len) ? stim[k[7:0] + 8'd1] : `NOP_INSN;
        end
        pos       = prog_len + 1;
        store_len = int'(stim[pos[7:0]][6:0]);
        for (int k = 0; k < 64; k++) begin
            pos = prog_len + 2 + 2 * k;
            exp_addr[k[5:0]] = (k < store_len) ? stim[pos[7:0]] : '0;
            exp_data[k[5:0]] = (k < store_len) ? stim[pos[7:0] + 8'd1] : '0;
        end
    endtask

    // Pattern follows the byte address of each word
    task automatic fill_data_memory();
        for (int a = 0; a < 256; a++) begin
            dmem[a[7:0]] = 32'h5a00_0000 | (a << 2);
        end
    endtask

    function automatic word_t fetch_word(word_t addr);
        if (int'(addr[31:2]) < prog_len) begin
            fetch_word = prog[addr[7:2]];
        end else begin
            fetch_word = `NOP_INSN;
        end
    endfunction

    always @(posedge clk) begin
        if (mem_write) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    // Fetch and load data follow the new pc and address
    // Read data only while the core signals a load
    always @(posedge clk) begin
        #1;
        inst      = fetch_word(pc);
        mem_rdata = mem_read ? dmem[mem_addr[9:2]] : '0;
    end

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------
    initial begin
        int   cycles;
        int   limit;
        int   missing;
        logic timed_out;
        rst_n     = 1'b0;
        inst      = `NOP_INSN;
        mem_rdata = '0;
        load_stimulus();
        fill_data_memory();
        limit = 4 * prog_len + 40;
        repeat (3) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        cycles = 0;
        while (!done && (cycles < limit)) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = !done;
        // Drain the pipeline so late stores still reach the checker
        if (!timed_out) begin
            repeat (8) @(posedge clk);
        end
        missing = store_len - store_idx;
        if (timed_out) begin
            $display("Timeout after %0d cycles, only %0d of %0d stores were seen",
                     cycles, store_idx, store_len);
        end
        $display("Error counts: %0d mismatched, %0d extra stores, %0d missing stores",
                 mismatch_cnt, extra_cnt, missing);
        if (!timed_out && (mismatch_cnt == 0) && (extra_cnt == 0) && (missing == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* riscv_pipe_core.f */
+incdir+.
riscv_pipe_pkg.sv
riscv_decoder.sv
riscv_regfile.sv
riscv_alu.sv
riscv_hazard_unit.sv
riscv_pipe_core.sv
riscv_pipe_props.sv
riscv_pipe_checker.sv
tb_riscv_pipe_core.sv

/* riscv_pipe_stimulus.hex */
// Word 0 is the instruction count, then one program word per entry
// After the program come the expected store count and address, data pairs
00000020
// Dependent arithmetic, forwarded from memory and writeback
00500093 00708113 002081B3 40118233 10302023 10402223
// Load followed at once by its use
10002283 00428333 10602423
// Taken beq and bne, each skipping two wrong stores
00410663 10302623 10302823 00209663 10302823 10302623
// Branches not taken
00208463 10102623 00411463 10202823
// Shifts and compares on a negative operand
FF000393 4023D413 0043D493 00339513 0013A5B3 0013B633 009446B3
10802A23 10902C23 10A02E23 12B02023 12C02223 12D02423
// Expected stores
0000000B
00000100 00000011
00000104 0000000C
00000108 0000001D
0000010C 00000005
00000110 0000000C
00000114 FFFFFFFC
00000118 0FFFFFFF
0000011C FFFFFF80
00000120 00000001
00000124 00000000
00000128 F0000003

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_riscv_pipe_core -f riscv_pipe_core.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -q "Test completed successfully" "$LOG"
if [ $? -ne 0 ]; then
    echo "FAIL: pass message not found in $LOG"
    exit 1
fi
echo "PASS"
exit 0
